//--- build.f
source/spmv_pkg.sv
source/csr_decoder.sv
source/weight_ram.sv
source/sparse_pe.sv
source/row_result_stage.sv
source/spmv_top.sv
verification/spmv_asserts.sv
verification/spmv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the spmv testbench with verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

obj_dir="obj_dir"
log_file="sim.log"

verilator --binary --timing --assert -Wno-fatal \
  --top-module spmv_tb \
  -f build.f \
  --Mdir "$obj_dir" \
  -o spmv_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status ${build_status}"
  exit 1
fi

"./${obj_dir}/spmv_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ "$sim_status" -ne 0 ]; then
  echo "simulator exited with status ${sim_status}"
fi

# the verdict comes only from the pass line in the log
if grep -qx "Simulation passed" "$log_file"; then
  echo "run_sim: pass"
  exit 0
else
  echo "run_sim: fail, see ${log_file}"
  exit 1
fi

//--- verification/spmv_tb.sv
`timescale 1ns/10ps

module spmv_tb;
  import spmv_pkg::*;

  localparam int B1_ROWS = 30;  // back to back random rows
  localparam int B2_ROWS = 30;  // gaps and empty rows
  localparam int B3_ROWS = 6;   // long rows that saturate
  localparam int B4_ROWS = 8;   // rows per matrix, sent as two matrices
  localparam int MAX_GAP = 3;
  // upper bound on stream and load cycles, a row takes at most 13 words plus gaps
  localparam int WORD_BOUND = 2 * WEIGHT_DEPTH + B1_ROWS * 13 + B2_ROWS * 13 * (MAX_GAP + 1)
                            + B3_ROWS * 256 + 2 * B4_ROWS * 13 * 2;
  localparam int TIMEOUT_CYCLES = WORD_BOUND + 40 * LATENCY + 200;
  localparam longint RES_MAX = (longint'(1) <<< (RESULT_WIDTH - 1)) - 1;
  localparam longint RES_MIN = -(longint'(1) <<< (RESULT_WIDTH - 1));

  typedef struct packed {
    logic signed [RESULT_WIDTH-1:0] value;
    logic [ROW_IDX_WIDTH-1:0]       idx;
    logic                           done;
    logic [31:0]                    cycle;  // cycle count at which row_valid_o is due
  } expect_t;

  logic                           clk;
  logic                           rst_n;
  logic                           wr_en_i;
  logic [COL_IDX_WIDTH-1:0]       wr_addr_i;
  logic [DATA_WIDTH-1:0]          wr_data_i;
  logic [ROW_IDX_WIDTH-1:0]       num_rows_i;
  logic                           word_valid_i;
  logic                           word_is_header_i;
  stream_payload_t                word_payload_i;
  logic                           row_valid_o;
  logic signed [RESULT_WIDTH-1:0] row_result_o;
  logic [ROW_IDX_WIDTH-1:0]       row_idx_o;
  logic                           matrix_done_o;
  logic                           stream_error_o;

  logic signed [DATA_WIDTH-1:0]   wt_model [WEIGHT_DEPTH];  // copy of the weight memory
  expect_t                        exp_q [$];
  int                             exp_row_cnt = 0;
  logic [31:0]                    cycle_cnt = '0;
  logic [31:0]                    last_sample_cycle;
  integer                         seed;

  spmv_top uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .wr_en_i          (wr_en_i),
    .wr_addr_i        (wr_addr_i),
    .wr_data_i        (wr_data_i),
    .num_rows_i       (num_rows_i),
    .word_valid_i     (word_valid_i),
    .word_is_header_i (word_is_header_i),
    .word_payload_i   (word_payload_i),
    .row_valid_o      (row_valid_o),
    .row_result_o     (row_result_o),
    .row_idx_o        (row_idx_o),
    .matrix_done_o    (matrix_done_o),
    .stream_error_o   (stream_error_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ########################################
  // helpers and model
  // ########################################

  task automatic check_value(input logic signed [63:0] actual,
                             input logic signed [63:0] expected, input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "check mismatch");
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  function automatic logic signed [RESULT_WIDTH-1:0] clamp_to_result(input longint sum);
    if (sum > RES_MAX) begin
      return RESULT_WIDTH'(RES_MAX);
    end else if (sum < RES_MIN) begin
      return RESULT_WIDTH'(RES_MIN);
    end
    return RESULT_WIDTH'(sum);
  endfunction

  // full_scale picks +max or -max per address, otherwise any random weight
  task automatic load_weights(input logic full_scale);
    logic signed [DATA_WIDTH-1:0] w;
    for (int a = 0; a < WEIGHT_DEPTH; a++) begin
      @(negedge clk);
      if (full_scale) begin
        w = ($random(seed) & 1) ? 16'sh8000 : 16'sh7fff;
      end else begin
        w = DATA_WIDTH'($random(seed));
      end
      wr_en_i     = 1'b1;
      wr_addr_i   = COL_IDX_WIDTH'(a);
      wr_data_i   = w;
      wt_model[a] = w;
    end
    @(negedge clk);
    wr_en_i = 1'b0;
  endtask

  task automatic drive_word(input logic is_hdr, input stream_payload_t pl, input int max_gap);
    int gap;
    gap = (max_gap > 0) ? rand_range(0, max_gap) : 0;
    repeat (gap) begin
      @(negedge clk);
      word_valid_i   = 1'b0;
      word_payload_i = PAYLOAD_WIDTH'($random(seed));  // junk while idle
    end
    @(negedge clk);
    word_valid_i      = 1'b1;
    word_is_header_i  = is_hdr;
    word_payload_i    = pl;
    last_sample_cycle = cycle_cnt + 1;  // taken on the coming rising edge
  endtask

  // sat_sign 0 gives random values, +1 or -1 pushes the sum toward that limit
  task automatic send_row(input int len, input int max_gap, input int sat_sign);
    stream_payload_t              pl;
    longint                       sum;
    int                           col;
    logic signed [DATA_WIDTH-1:0] val;
    expect_t                      e;
    sum = 0;
    pl.header.row_len = ROW_LEN_WIDTH'(len);
    pl.header.unused  = '0;
    drive_word(1'b1, pl, max_gap);
    for (int i = 0; i < len; i++) begin
      col = rand_range(0, WEIGHT_DEPTH - 1);
      if (sat_sign == 0) begin
        val = DATA_WIDTH'($random(seed));
      end else if ((sat_sign > 0) == (wt_model[col] >= 0)) begin
        val = 16'sh7fff;
      end else begin
        val = 16'sh8000;
      end
      pl.entry.col_idx = COL_IDX_WIDTH'(col);
      pl.entry.value   = val;
      sum += longint'(val) * longint'(wt_model[col]);
      drive_word(1'b0, pl, max_gap);
    end
    e.value = clamp_to_result(sum);
    e.idx   = ROW_IDX_WIDTH'(exp_row_cnt);
    e.done  = (exp_row_cnt == int'(num_rows_i) - 1);
    e.cycle = last_sample_cycle + LATENCY;
    exp_q.push_back(e);
    exp_row_cnt = e.done ? 0 : exp_row_cnt + 1;  // numbering restarts per matrix
  endtask

  task automatic wait_drain();
    @(negedge clk);
    word_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  // ########################################
  // result monitor
  // ########################################

  always @(negedge clk) begin : result_monitor
    expect_t e;
    if (rst_n && row_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("a row result came out at %0t with no row outstanding", $time);
        $display("Simulation failed");
        $fatal(1, "unexpected row result");
      end else begin
        e = exp_q.pop_front();
        check_value(row_result_o, e.value, "row sum");
        check_value(row_idx_o, e.idx, "row index");
        check_value(matrix_done_o, e.done, "matrix_done_o");
        check_value(cycle_cnt, e.cycle, "result cycle");
      end
    end
  end

  // ########################################
  // stimulus
  // ########################################

  initial begin : stimulus
    stream_payload_t pl;
    int              wait_cycles;
    seed             = 32'ha8a2_ebb6;
    rst_n            = 1'b0;
    wr_en_i          = 1'b0;
    wr_addr_i        = '0;
    wr_data_i        = '0;
    num_rows_i       = '0;
    word_valid_i     = 1'b0;
    word_is_header_i = 1'b0;
    word_payload_i   = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    load_weights(1'b0);

    num_rows_i = ROW_IDX_WIDTH'(B1_ROWS);  // random rows with no gaps
    for (int r = 0; r < B1_ROWS; r++) send_row(rand_range(1, 12), 0, 0);
    wait_drain();

    num_rows_i = ROW_IDX_WIDTH'(B2_ROWS);  // about a quarter of these rows are empty
    for (int r = 0; r < B2_ROWS; r++) begin
      send_row((rand_range(0, 3) == 0) ? 0 : rand_range(1, 12), MAX_GAP, 0);
    end
    wait_drain();

    load_weights(1'b1);
    num_rows_i = ROW_IDX_WIDTH'(B3_ROWS);
    for (int r = 0; r < B3_ROWS; r++) send_row(rand_range(200, 255), 0, (r % 2) ? -1 : 1);
    wait_drain();

    // two matrices back to back, numbering must restart between them
    num_rows_i = ROW_IDX_WIDTH'(B4_ROWS);
    for (int r = 0; r < 2 * B4_ROWS; r++) send_row(rand_range(1, 12), 1, 0);
    wait_drain();

    // an entry with no open row is a protocol error
    check_value(stream_error_o, 1'b0, "stream_error_o before the stray entry");
    pl.entry.col_idx = 8'h11;
    pl.entry.value   = 16'sh0123;
    drive_word(1'b0, pl, 0);
    @(negedge clk);
    word_valid_i = 1'b0;
    wait_cycles  = 0;
    while (!stream_error_o && wait_cycles < 4) begin
      @(negedge clk);
      wait_cycles++;
    end
    check_value(stream_error_o, 1'b1, "stream_error_o after an entry outside a row");
    repeat (2 * LATENCY) begin
      @(negedge clk);
      check_value(stream_error_o, 1'b1, "stream_error_o held");
    end

    wait_drain();
    if (exp_q.size() != 0) begin
      $display("%0d rows never produced a result", exp_q.size());
      $display("Simulation failed");
      $fatal(1, "missing row results");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $fatal(1, "run timed out");
  end

endmodule

//--- verification/spmv_asserts.sv
`timescale 1ns/10ps

module spmv_asserts (
  input logic clk,
  input logic rst_n,
  input logic row_valid_i,
  input logic matrix_done_i,
  input logic stream_error_i
);
  import spmv_pkg::*;

  logic [3:0] cycles_since_rst_q;  // stops counting once the pipeline could be full

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycles_since_rst_q <= '0;
    end else if (cycles_since_rst_q < 4'(LATENCY)) begin
      cycles_since_rst_q <= cycles_since_rst_q + 4'd1;
    end
  end

  // ########################################
  // output protocol
  // ########################################

  done_with_row: assert property (@(posedge clk) disable iff (!rst_n)
    matrix_done_i |-> row_valid_i)
    else $error("matrix_done_o without row_valid_o");

  error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    stream_error_i |=> stream_error_i)
    else $error("stream_error_o cleared without a reset");

  // nothing can leave the pipeline before its depth has passed
  quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    (cycles_since_rst_q < 4'(LATENCY)) |-> !row_valid_i)
    else $error("row_valid_o too early after reset");

endmodule

bind spmv_top spmv_asserts u_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .row_valid_i    (row_valid_o),
  .matrix_done_i  (matrix_done_o),
  .stream_error_i (stream_error_o)
);

//--- source/spmv_top.sv
`timescale 1ns/10ps

module spmv_top (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     wr_en_i,
  input  logic [spmv_pkg::COL_IDX_WIDTH-1:0]       wr_addr_i,
  input  logic [spmv_pkg::DATA_WIDTH-1:0]          wr_data_i,
  input  logic [spmv_pkg::ROW_IDX_WIDTH-1:0]       num_rows_i,
  input  logic                                     word_valid_i,
  input  logic                                     word_is_header_i,
  input  spmv_pkg::stream_payload_t                word_payload_i,
  output logic                                     row_valid_o,
  output logic signed [spmv_pkg::RESULT_WIDTH-1:0] row_result_o,
  output logic [spmv_pkg::ROW_IDX_WIDTH-1:0]       row_idx_o,
  output logic                                     matrix_done_o,
  output logic                                     stream_error_o
);
  import spmv_pkg::*;

  // decode to memory and execute
  logic                         rd_en;
  logic [COL_IDX_WIDTH-1:0]     rd_addr;
  logic [DATA_WIDTH-1:0]        rd_data;
  logic                         ent_valid;
  logic signed [DATA_WIDTH-1:0] ent_value;
  logic                         ent_first;
  logic                         ent_last;

  // execute to result
  logic                         sum_valid;
  logic signed [ACC_WIDTH-1:0]  sum_value;

  // ########################################
  // pipeline
  // ########################################

  csr_decoder u_decoder (
    .clk              (clk),
    .rst_n            (rst_n),
    .word_valid_i     (word_valid_i),
    .word_is_header_i (word_is_header_i),
    .word_payload_i   (word_payload_i),
    .rd_en_o          (rd_en),
    .rd_addr_o        (rd_addr),
    .ent_valid_o      (ent_valid),
    .ent_value_o      (ent_value),
    .ent_first_o      (ent_first),
    .ent_last_o       (ent_last),
    .stream_error_o   (stream_error_o)
  );

  weight_ram u_weights (
    .clk       (clk),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  sparse_pe u_pe (
    .clk         (clk),
    .rst_n       (rst_n),
    .ent_valid_i (ent_valid),
    .ent_value_i (ent_value),
    .ent_first_i (ent_first),
    .ent_last_i  (ent_last),
    .weight_i    (rd_data),      // arrives with the delayed entry
    .sum_valid_o (sum_valid),
    .sum_value_o (sum_value)
  );

  row_result_stage u_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .sum_valid_i   (sum_valid),
    .sum_value_i   (sum_value),
    .num_rows_i    (num_rows_i),
    .row_valid_o   (row_valid_o),
    .row_result_o  (row_result_o),
    .row_idx_o     (row_idx_o),
    .matrix_done_o (matrix_done_o)
  );

endmodule

//--- source/row_result_stage.sv
`timescale 1ns/10ps

module row_result_stage (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     sum_valid_i,
  input  logic signed [spmv_pkg::ACC_WIDTH-1:0]    sum_value_i,
  input  logic [spmv_pkg::ROW_IDX_WIDTH-1:0]       num_rows_i,
  output logic                                     row_valid_o,
  output logic signed [spmv_pkg::RESULT_WIDTH-1:0] row_result_o,
  output logic [spmv_pkg::ROW_IDX_WIDTH-1:0]       row_idx_o,
  output logic                                     matrix_done_o
);
  import spmv_pkg::*;

  logic [ACC_WIDTH-RESULT_WIDTH:0]    top_bits;
  logic                               fits;
  logic signed [RESULT_WIDTH-1:0]     sat_value;
  logic [ROW_IDX_WIDTH-1:0]           row_cnt_q;      // number of the next row
  logic [ROW_IDX_WIDTH-1:0]           last_row_idx;
  logic                               is_last;

  // ########################################
  // saturation
  // ########################################

  // the sum fits when every bit above the result sign matches that sign
  assign top_bits = sum_value_i[ACC_WIDTH-1:RESULT_WIDTH-1];
  assign fits     = (&top_bits) || !(|top_bits);

  always_comb begin
    if (fits) begin
      sat_value = sum_value_i[RESULT_WIDTH-1:0];
    end else if (sum_value_i[ACC_WIDTH-1]) begin
      sat_value = {1'b1, {(RESULT_WIDTH-1){1'b0}}};  // most negative
    end else begin
      sat_value = {1'b0, {(RESULT_WIDTH-1){1'b1}}};  // most positive
    end
  end

  // ########################################
  // row numbering
  // ########################################

  assign last_row_idx = num_rows_i - 1'b1;
  assign is_last      = (row_cnt_q == last_row_idx);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_cnt_q     <= '0;
      row_valid_o   <= 1'b0;
      matrix_done_o <= 1'b0;
    end else begin
      row_valid_o   <= sum_valid_i;
      matrix_done_o <= sum_valid_i && is_last;
      if (sum_valid_i) begin
        // wrap so the next matrix numbers its rows from 0 again
        row_cnt_q <= is_last ? '0 : row_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sum_valid_i) begin
      row_result_o <= sat_value;
      row_idx_o    <= row_cnt_q;
    end
  end

endmodule

//--- source/sparse_pe.sv
`timescale 1ns/10ps

module sparse_pe (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   ent_valid_i,
  input  logic signed [spmv_pkg::DATA_WIDTH-1:0] ent_value_i,
  input  logic                                   ent_first_i,
  input  logic                                   ent_last_i,
  input  logic signed [spmv_pkg::DATA_WIDTH-1:0] weight_i,
  output logic                                   sum_valid_o,
  output logic signed [spmv_pkg::ACC_WIDTH-1:0]  sum_value_o
);
  import spmv_pkg::*;

  // stage a, entry lined up with the weight read
  logic                           a_valid_q;
  logic                           a_first_q;
  logic                           a_last_q;
  logic signed [DATA_WIDTH-1:0]   a_value_q;

  // stage b, registered product
  logic signed [2*DATA_WIDTH-1:0] mult;
  logic                           b_valid_q;
  logic                           b_first_q;
  logic                           b_last_q;
  logic signed [2*DATA_WIDTH-1:0] b_product_q;

  // stage c, per row accumulation
  logic signed [ACC_WIDTH-1:0]    product_ext;
  logic signed [ACC_WIDTH-1:0]    acc_q;

  // ########################################
  // align with memory data
  // ########################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_valid_q <= 1'b0;
      a_first_q <= 1'b0;
      a_last_q  <= 1'b0;
    end else begin
      a_valid_q <= ent_valid_i;
      a_first_q <= ent_first_i;
      a_last_q  <= ent_last_i;
    end
  end

  always_ff @(posedge clk) begin
    a_value_q <= ent_value_i;
  end

  // ########################################
  // multiply
  // ########################################

  // a zero value skips the weight, the read was never issued for empty rows
  assign mult = (a_value_q == '0) ? (2*DATA_WIDTH)'(0) : a_value_q * weight_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_valid_q <= 1'b0;
      b_first_q <= 1'b0;
      b_last_q  <= 1'b0;
    end else begin
      b_valid_q <= a_valid_q;
      b_first_q <= a_first_q;
      b_last_q  <= a_last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (a_valid_q) begin
      b_product_q <= mult;
    end
  end

  // ########################################
  // accumulate
  // ########################################

  assign product_ext = b_product_q;  // sign extension to the accumulator width

  // flags travel with each product, so the next row can start right
  // behind the last entry of the previous one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q       <= '0;
      sum_valid_o <= 1'b0;
    end else begin
      sum_valid_o <= b_valid_q && b_last_q;
      if (b_valid_q) begin
        acc_q <= b_first_q ? product_ext : acc_q + product_ext;
      end
    end
  end

  assign sum_value_o = acc_q;  // final row sum on the cycle of sum_valid_o

endmodule

//--- source/weight_ram.sv
`timescale 1ns/10ps

module weight_ram (
  input  logic                               clk,
  input  logic                               wr_en_i,
  input  logic [spmv_pkg::COL_IDX_WIDTH-1:0] wr_addr_i,
  input  logic [spmv_pkg::DATA_WIDTH-1:0]    wr_data_i,
  input  logic                               rd_en_i,
  input  logic [spmv_pkg::COL_IDX_WIDTH-1:0] rd_addr_i,
  output logic [spmv_pkg::DATA_WIDTH-1:0]    rd_data_o
);
  import spmv_pkg::*;

  // ########################################
  // dense vector storage
  // ########################################

  // one word per column, indexed directly by the column index
  logic [DATA_WIDTH-1:0] mem [WEIGHT_DEPTH];

  // the vector is loaded from outside before the stream starts
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // ########################################
  // read port
  // ########################################

  // registered read, data shows up the cycle after rd_en_i
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];  // holds the last word while idle
    end
  end

  // a write and a read on the same address in one cycle return the old word,
  // which cannot happen in normal use since loading ends before the stream

endmodule

//--- source/csr_decoder.sv
`timescale 1ns/10ps

module csr_decoder (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   word_valid_i,
  input  logic                                   word_is_header_i,
  input  spmv_pkg::stream_payload_t              word_payload_i,
  output logic                                   rd_en_o,
  output logic [spmv_pkg::COL_IDX_WIDTH-1:0]     rd_addr_o,
  output logic                                   ent_valid_o,
  output logic signed [spmv_pkg::DATA_WIDTH-1:0] ent_value_o,
  output logic                                   ent_first_o,
  output logic                                   ent_last_o,
  output logic                                   stream_error_o
);
  import spmv_pkg::*;

  logic                     word_valid_q;
  logic                     word_is_header_q;
  stream_payload_t          word_payload_q;

  logic [ROW_LEN_WIDTH-1:0] remain_q;         // entries still expected in the open row
  logic                     first_pending_q;  // next entry opens the accumulation
  logic                     row_open;
  logic                     hdr_word;
  logic                     ent_word;
  logic                     bad_word;

  // ########################################
  // stream sampling
  // ########################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid_q <= 1'b0;
    end else begin
      word_valid_q <= word_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    word_is_header_q <= word_is_header_i;
    word_payload_q   <= word_payload_i;
  end

  // ########################################
  // decode
  // ########################################

  assign row_open = (remain_q != '0);
  assign hdr_word = word_valid_q && word_is_header_q;
  assign ent_word = word_valid_q && !word_is_header_q;

  // a header inside a row or an entry outside one is dropped
  assign bad_word = (hdr_word && row_open) || (ent_word && !row_open);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      remain_q        <= '0;
      first_pending_q <= 1'b0;
      rd_en_o         <= 1'b0;
      ent_valid_o     <= 1'b0;
      ent_first_o     <= 1'b0;
      ent_last_o      <= 1'b0;
      stream_error_o  <= 1'b0;
    end else begin
      rd_en_o     <= 1'b0;
      ent_valid_o <= 1'b0;
      ent_first_o <= 1'b0;
      ent_last_o  <= 1'b0;
      if (bad_word) begin
        stream_error_o <= 1'b1;  // sticky until reset
      end else if (hdr_word) begin
        if (word_payload_q.header.row_len == '0) begin
          // empty row still needs a result, send a zero entry that needs no weight
          ent_valid_o <= 1'b1;
          ent_first_o <= 1'b1;
          ent_last_o  <= 1'b1;
        end else begin
          remain_q        <= word_payload_q.header.row_len;
          first_pending_q <= 1'b1;
        end
      end else if (ent_word) begin
        ent_valid_o     <= 1'b1;
        rd_en_o         <= 1'b1;
        ent_first_o     <= first_pending_q;
        ent_last_o      <= (remain_q == ROW_LEN_WIDTH'(1));
        remain_q        <= remain_q - 1'b1;
        first_pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_word) begin
      ent_value_o <= '0;  // pseudo entry of an empty row
    end else if (ent_word) begin
      ent_value_o <= word_payload_q.entry.value;
      rd_addr_o   <= word_payload_q.entry.col_idx;
    end
  end

endmodule

//--- source/spmv_pkg.sv
package spmv_pkg;

  // ########################################
  // widths and sizes
  // ########################################

  localparam int DATA_WIDTH    = 16;   // signed matrix values and weights
  localparam int COL_IDX_WIDTH = 8;
  localparam int WEIGHT_DEPTH  = 256;  // one weight per column index
  localparam int ROW_LEN_WIDTH = 8;    // a row holds 0 to 255 entries
  localparam int ACC_WIDTH     = 40;   // 255 full scale products fit without overflow
  localparam int RESULT_WIDTH  = 32;   // row sums beyond this range saturate
  localparam int ROW_IDX_WIDTH = 10;
  localparam int PAYLOAD_WIDTH = 24;

  // cycles from the edge that samples the last word of a row to row_valid_o
  localparam int LATENCY       = 5;

  // ########################################
  // stream word layouts
  // ########################################

  // a header word only gives the number of entries that follow
  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0]               row_len;
    logic [PAYLOAD_WIDTH-ROW_LEN_WIDTH-1:0] unused;
  } row_header_t;

  typedef struct packed {
    logic        [COL_IDX_WIDTH-1:0] col_idx;  // selects the weight
    logic signed [DATA_WIDTH-1:0]    value;
  } row_entry_t;

  // the header bit next to the payload picks the view
  typedef union packed {
    row_header_t header;
    row_entry_t  entry;
  } stream_payload_t;

endpackage
